/* logic/blackjack_pkg.sv */
// Game enums, card, hand and status structs, VGA bus struct,
// button rectangles and table colors.
package blackjack_pkg;

    typedef enum logic [2:0] {
        IDLE,
        DEAL,
        PLAYER_TURN,
        DEALER_TURN,
        RESULT
    } game_state_t;

    typedef enum logic [1:0] {CMD_NONE, CMD_DEAL, CMD_HIT, CMD_STAND} cmd_t;

    typedef enum logic [1:0] {NONE, PLAYER_WIN, DEALER_WIN, PUSH} outcome_t;

    localparam int MAX_CARDS = 5;   // Card slots in one hand.

    typedef logic [3:0] rank_t;     // 1 is the ace, 11 to 13 are the face cards.

    typedef struct packed {
        rank_t [MAX_CARDS-1:0] ranks;
        logic  [2:0]           count;
    } hand_t;

    typedef struct packed {
        game_state_t state;
        outcome_t    outcome;
        logic [4:0]  player_total;
        logic [4:0]  dealer_total;
        logic [2:0]  player_count;
        logic [2:0]  dealer_count;
    } game_status_t;

    typedef struct packed {
        logic [10:0] h_count;
        logic [10:0] v_count;
        logic        hsync;
        logic        vsync;
        logic        blank;
    } vga_bus_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Buttons along the bottom of the screen.
    localparam logic [11:0] BTN_DEAL_X  = 12'd80;
    localparam logic [11:0] BTN_DEAL_Y  = 12'd420;
    localparam logic [11:0] BTN_DEAL_W  = 12'd120;
    localparam logic [11:0] BTN_DEAL_H  = 12'd40;
    localparam logic [11:0] BTN_HIT_X   = 12'd260;
    localparam logic [11:0] BTN_HIT_Y   = 12'd420;
    localparam logic [11:0] BTN_HIT_W   = 12'd120;
    localparam logic [11:0] BTN_HIT_H   = 12'd40;
    localparam logic [11:0] BTN_STAND_X = 12'd440;
    localparam logic [11:0] BTN_STAND_Y = 12'd420;
    localparam logic [11:0] BTN_STAND_W = 12'd120;
    localparam logic [11:0] BTN_STAND_H = 12'd40;

    // The rectangle covers rx to rx+w-1 and ry to ry+h-1, both edges included.
    function automatic logic in_rect(logic [11:0] x, logic [11:0] y, logic [11:0] rx,
                                     logic [11:0] ry, logic [11:0] w, logic [11:0] h);
        return (x >= rx) && (x < rx + w) && (y >= ry) && (y < ry + h);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    localparam rgb_t COLOR_TABLE   = '{r: 4'h1, g: 4'h7, b: 4'h2};
    localparam rgb_t COLOR_CARD    = '{r: 4'hf, g: 4'hf, b: 4'hf};
    localparam rgb_t COLOR_BAR     = '{r: 4'h0, g: 4'h0, b: 4'h0};
    localparam rgb_t COLOR_BTN_ON  = '{r: 4'hf, g: 4'hc, b: 4'h2};
    localparam rgb_t COLOR_BTN_OFF = '{r: 4'h5, g: 4'h5, b: 4'h4};

endpackage

/* logic/vga_timing.sv */
// Horizontal and vertical counters with sync and blanking generation.
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output blackjack_pkg::vga_bus_t vga
);
    import blackjack_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [10:0] h_next;
    logic [10:0] v_next;

    // The line counter steps when the pixel counter wraps.
    always_comb begin
        h_next = vga.h_count + 11'd1;
        v_next = vga.v_count;
        if (vga.h_count == 11'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vga.v_count == 11'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vga.v_count + 11'd1;
            end
        end
    end

    // Sync and blank are derived from the next counts, so the whole bus
    // describes the same pixel in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga <= '{h_count: '0, v_count: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
        end else begin
            vga.h_count <= h_next;
            vga.v_count <= v_next;
            vga.hsync   <= !((h_next >= 11'(H_SYNC_START)) &&
                             (h_next <  11'(H_SYNC_START + H_SYNC)));  // Active low.
            vga.vsync   <= !((v_next >= 11'(V_SYNC_START)) &&
                             (v_next <  11'(V_SYNC_START + V_SYNC)));
            vga.blank   <= (h_next >= 11'(H_ACTIVE)) || (v_next >= 11'(V_ACTIVE));
        end
    end

endmodule

/* logic/button_click.sv */
// Mouse press detection and button hit decoding.
module button_click (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [11:0]         mouse_x,
    input  logic [11:0]         mouse_y,
    input  logic                mouse_left,
    output blackjack_pkg::cmd_t cmd
);
    import blackjack_pkg::*;

    logic left_q;   // Button level at the previous edge.
    logic press;
    cmd_t cmd_next;

    assign press = mouse_left && !left_q;

    always_comb begin
        cmd_next = CMD_NONE;
        if (press) begin
            if (in_rect(mouse_x, mouse_y, BTN_DEAL_X, BTN_DEAL_Y, BTN_DEAL_W, BTN_DEAL_H)) begin
                cmd_next = CMD_DEAL;
            end else if (in_rect(mouse_x, mouse_y, BTN_HIT_X, BTN_HIT_Y,
                                 BTN_HIT_W, BTN_HIT_H)) begin
                cmd_next = CMD_HIT;
            end else if (in_rect(mouse_x, mouse_y, BTN_STAND_X, BTN_STAND_Y,
                                 BTN_STAND_W, BTN_STAND_H)) begin
                cmd_next = CMD_STAND;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_q <= 1'b0;
            cmd    <= CMD_NONE;
        end else begin
            left_q <= mouse_left;
            cmd    <= cmd_next;    // Held for one cycle only.
        end
    end

endmodule

/* logic/card_dealer.sv */
// Pseudo-random card source built on a free-running xorshift LFSR.
module card_dealer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 draw_req,
    output logic                 card_valid,
    output blackjack_pkg::rank_t card_rank
);
    import blackjack_pkg::*;

    localparam logic [15:0] SEED = 16'hace1;

    logic [15:0] lfsr;
    logic [15:0] mix_a;
    logic [15:0] mix_b;
    logic [15:0] lfsr_next;
    logic        pending;
    logic        in_range;

    // Shift triple 7, 9, 8 gives the full period for a 16-bit state.
    always_comb begin
        mix_a     = lfsr ^ (lfsr << 7);
        mix_b     = mix_a ^ (mix_a >> 9);
        lfsr_next = mix_b ^ (mix_b << 8);
    end

    assign in_range = (lfsr[3:0] != 4'd0) && (lfsr[3:0] <= 4'd13);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr       <= SEED;
            pending    <= 1'b0;
            card_valid <= 1'b0;
        end else begin
            lfsr       <= lfsr_next;
            card_valid <= 1'b0;
            if ((pending || draw_req) && in_range) begin
                card_valid <= 1'b1;
                pending    <= 1'b0;
            end else if (draw_req) begin
                pending    <= 1'b1;     // Wait for a usable nibble.
            end
        end
    end

    // The rank is payload and only meaningful alongside card_valid.
    always_ff @(posedge clk) begin
        if ((pending || draw_req) && in_range) begin
            card_rank <= lfsr[3:0];
        end
    end

endmodule

/* logic/blackjack_fsm.sv */
// Game state machine with hand storage, scoring and outcome decision.
module blackjack_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  blackjack_pkg::cmd_t         cmd,
    input  logic                        card_valid,
    input  blackjack_pkg::rank_t        card_rank,
    output logic                        draw_req,
    output blackjack_pkg::hand_t        player_hand,
    output blackjack_pkg::hand_t        dealer_hand,
    output blackjack_pkg::game_status_t status
);
    import blackjack_pkg::*;

    game_state_t game_state;
    outcome_t    outcome;
    logic        waiting;       // A card request is outstanding.
    logic [4:0]  player_total;
    logic [4:0]  dealer_total;

    // Totals stay below 32 because a bust ends the player's turn and the
    // dealer stops drawing at 17.
    function automatic logic [4:0] hand_total(hand_t hand);
        logic [4:0] sum;
        logic       has_ace;
        sum     = '0;
        has_ace = 1'b0;
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (3'(i) < hand.count) begin
                if (hand.ranks[i] == 4'd1) begin
                    has_ace = 1'b1;
                end
                sum = sum + ((hand.ranks[i] > 4'd10) ? 5'd10 : {1'b0, hand.ranks[i]});
            end
        end
        if (has_ace && (sum <= 5'd11)) begin
            sum = sum + 5'd10;      // One ace counts as eleven.
        end
        return sum;
    endfunction

    assign player_total = hand_total(player_hand);
    assign dealer_total = hand_total(dealer_hand);

    assign status = '{state: game_state, outcome: outcome,
                      player_total: player_total, dealer_total: dealer_total,
                      player_count: player_hand.count, dealer_count: dealer_hand.count};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_state  <= IDLE;
            outcome     <= NONE;
            waiting     <= 1'b0;
            draw_req    <= 1'b0;
            player_hand <= '0;
            dealer_hand <= '0;
        end else begin
            draw_req <= 1'b0;
            if (card_valid) begin
                waiting <= 1'b0;
            end
            case (game_state)
                IDLE, RESULT: begin
                    if (cmd == CMD_DEAL) begin
                        player_hand <= '0;
                        dealer_hand <= '0;
                        outcome     <= NONE;
                        game_state  <= DEAL;
                    end
                end
                // ~~~~~~~~~~~~~~~~~~~~
                DEAL: begin
                    if (card_valid && (player_hand.count < 3'd2)) begin
                        player_hand.ranks[player_hand.count] <= card_rank;
                        player_hand.count <= player_hand.count + 3'd1;
                    end else if (card_valid) begin
                        dealer_hand.ranks[dealer_hand.count] <= card_rank;
                        dealer_hand.count <= dealer_hand.count + 3'd1;
                    end else if (dealer_hand.count == 3'd2) begin
                        game_state <= PLAYER_TURN;
                    end else if (!waiting) begin
                        draw_req <= 1'b1;
                        waiting  <= 1'b1;
                    end
                end
                PLAYER_TURN: begin
                    if (card_valid) begin
                        player_hand.ranks[player_hand.count] <= card_rank;
                        player_hand.count <= player_hand.count + 3'd1;
                    end else if (!waiting) begin
                        if (player_total > 5'd21) begin
                            outcome    <= DEALER_WIN;
                            game_state <= RESULT;
                        end else if ((cmd == CMD_HIT) &&
                                     (player_hand.count < 3'(MAX_CARDS))) begin
                            draw_req <= 1'b1;
                            waiting  <= 1'b1;
                        end else if (cmd == CMD_STAND) begin
                            game_state <= DEALER_TURN;
                        end
                    end
                end
                DEALER_TURN: begin
                    if (card_valid) begin
                        dealer_hand.ranks[dealer_hand.count] <= card_rank;
                        dealer_hand.count <= dealer_hand.count + 3'd1;
                    end else if (!waiting) begin
                        if ((dealer_total < 5'd17) && (dealer_hand.count < 3'(MAX_CARDS))) begin
                            draw_req <= 1'b1;
                            waiting  <= 1'b1;
                        end else begin
                            game_state <= RESULT;
                            if ((dealer_total > 5'd21) || (player_total > dealer_total)) begin
                                outcome <= PLAYER_WIN;
                            end else if (dealer_total > player_total) begin
                                outcome <= DEALER_WIN;
                            end else begin
                                outcome <= PUSH;
                            end
                        end
                    end
                end
                default: game_state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/draw_table.sv */
// Pixel stage for the table, both hands and the three buttons.
module draw_table (
    input  logic                       clk,
    input  logic                       rst_n,
    input  blackjack_pkg::vga_bus_t    vga,
    input  blackjack_pkg::hand_t       player_hand,
    input  blackjack_pkg::hand_t       dealer_hand,
    input  blackjack_pkg::game_state_t state,
    output logic                       hsync,
    output logic                       vsync,
    output blackjack_pkg::rgb_t        rgb
);
    import blackjack_pkg::*;

    // Card geometry in pixels.
    localparam int CARD_X0    = 40;
    localparam int CARD_PITCH = 52;
    localparam int CARD_W     = 40;
    localparam int CARD_H     = 60;
    localparam int DEALER_Y   = 60;
    localparam int PLAYER_Y   = 260;
    localparam int BAR_MARGIN = 4;
    localparam int BAR_W      = 8;
    localparam int BAR_STEP   = 4;     // Bar height per rank step.

    localparam logic [1:0] PIX_NONE = 2'd0;
    localparam logic [1:0] PIX_CARD = 2'd1;
    localparam logic [1:0] PIX_BAR  = 2'd2;

    logic [11:0] px;
    logic [11:0] py;
    logic [1:0]  dealer_pix;
    logic [1:0]  player_pix;
    logic        deal_on;
    logic        play_on;
    rgb_t        pix;

    // Classifies the pixel against one row of cards.
    function automatic logic [1:0] card_pixel(hand_t hand, logic [10:0] x, logic [10:0] y,
                                              logic [10:0] row_y);
        logic [10:0] cx;
        logic [10:0] bar_top;
        logic [10:0] bar_bottom;
        card_pixel = PIX_NONE;
        bar_bottom = row_y + 11'(CARD_H - BAR_MARGIN);
        for (int i = 0; i < MAX_CARDS; i++) begin
            cx      = 11'(CARD_X0 + i * CARD_PITCH);
            bar_top = bar_bottom - 11'(hand.ranks[i]) * 11'(BAR_STEP);
            if ((3'(i) < hand.count) && (x >= cx) && (x < cx + 11'(CARD_W)) &&
                (y >= row_y) && (y < row_y + 11'(CARD_H))) begin
                if ((x >= cx + 11'(BAR_MARGIN)) && (x < cx + 11'(BAR_MARGIN + BAR_W)) &&
                    (y >= bar_top) && (y < bar_bottom)) begin
                    card_pixel = PIX_BAR;
                end else begin
                    card_pixel = PIX_CARD;
                end
            end
        end
    endfunction

    assign px         = {1'b0, vga.h_count};
    assign py         = {1'b0, vga.v_count};
    assign dealer_pix = card_pixel(dealer_hand, vga.h_count, vga.v_count, 11'(DEALER_Y));
    assign player_pix = card_pixel(player_hand, vga.h_count, vga.v_count, 11'(PLAYER_Y));
    assign deal_on    = (state == IDLE) || (state == RESULT);
    assign play_on    = (state == PLAYER_TURN);   // Hit and stand share this.

    always_comb begin
        pix = COLOR_TABLE;
        if ((dealer_pix == PIX_BAR) || (player_pix == PIX_BAR)) begin
            pix = COLOR_BAR;
        end else if ((dealer_pix == PIX_CARD) || (player_pix == PIX_CARD)) begin
            pix = COLOR_CARD;
        end else if (in_rect(px, py, BTN_DEAL_X, BTN_DEAL_Y, BTN_DEAL_W, BTN_DEAL_H)) begin
            pix = deal_on ? COLOR_BTN_ON : COLOR_BTN_OFF;
        end else if (in_rect(px, py, BTN_HIT_X, BTN_HIT_Y, BTN_HIT_W, BTN_HIT_H) ||
                     in_rect(px, py, BTN_STAND_X, BTN_STAND_Y, BTN_STAND_W, BTN_STAND_H)) begin
            pix = play_on ? COLOR_BTN_ON : COLOR_BTN_OFF;
        end
    end

    // One register stage keeps the syncs aligned with the colour.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else begin
            hsync <= vga.hsync;
            vsync <= vga.vsync;
            rgb   <= vga.blank ? '0 : pix;  // Black outside the active area.
        end
    end

endmodule

/* logic/top_blackjack.sv */
// Top level of the blackjack table, with the timing parameters passed down.
module top_blackjack #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [11:0]                 mouse_x,
    input  logic [11:0]                 mouse_y,
    input  logic                        mouse_left,
    output logic                        hsync,
    output logic                        vsync,
    output blackjack_pkg::rgb_t         rgb,
    output blackjack_pkg::game_status_t status
);
    import blackjack_pkg::*;

    vga_bus_t vga;
    cmd_t     cmd;
    logic     draw_req;
    logic     card_valid;
    rank_t    card_rank;
    hand_t    player_hand;
    hand_t    dealer_hand;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (.clk, .rst_n, .vga);

    button_click u_button_click (.clk, .rst_n, .mouse_x, .mouse_y, .mouse_left, .cmd);

    card_dealer u_card_dealer (.clk, .rst_n, .draw_req, .card_valid, .card_rank);

    blackjack_fsm u_blackjack_fsm (
        .clk, .rst_n, .cmd, .card_valid, .card_rank,
        .draw_req, .player_hand, .dealer_hand, .status
    );

    draw_table u_draw_table (
        .clk, .rst_n, .vga, .player_hand, .dealer_hand, .state(status.state),
        .hsync, .vsync, .rgb
    );

endmodule

/* verif/top_blackjack_assert.sv */
// Bound checker for reset values, video timing, command filtering
// and the game rules of the blackjack table.
module top_blackjack_assert #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic [11:0]                 mouse_x,
    input logic [11:0]                 mouse_y,
    input logic                        mouse_left,
    input logic                        hsync,
    input logic                        vsync,
    input blackjack_pkg::rgb_t         rgb,
    input blackjack_pkg::game_status_t status
);
    import blackjack_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam game_status_t RESET_STATUS = '{state: IDLE, outcome: NONE, default: '0};

    int           fail_count = 0;   // Read by the testbench for its summary.
    logic         hsync_q;
    logic         vsync_q;
    logic         h_fall;
    logic         v_fall;
    logic         h_seen;           // Position tracking is valid after the first edges.
    logic         v_seen;
    int           h_low;            // Cycles with hsync low so far.
    int           v_low;
    int           h_period;         // Cycles since the last hsync fall.
    int           h_pos;
    int           v_pos;
    int           h_here;
    int           v_here;
    game_status_t status_q;
    outcome_t     outcome_exp;
    logic         left_q;           // Mouse button level at the previous edge.
    logic         deal_press;
    logic         deal_q;           // A press on the deal button was sampled one edge ago.

    assign h_fall = hsync_q && !hsync;
    assign v_fall = vsync_q && !vsync;

    // A falling sync edge pins the pixel position to the start of its sync window.
    assign h_here = h_fall ? (H_ACTIVE + H_FRONT) : h_pos;
    assign v_here = v_fall ? (V_ACTIVE + V_FRONT) : v_pos;

    // A press counts for the deal button from its first to its last pixel.
    assign deal_press = mouse_left && !left_q &&
                        (mouse_x >= BTN_DEAL_X) && (mouse_x <= BTN_DEAL_X + BTN_DEAL_W - 12'd1) &&
                        (mouse_y >= BTN_DEAL_Y) && (mouse_y <= BTN_DEAL_Y + BTN_DEAL_H - 12'd1);

    // A player bust loses first, then a dealer bust, then the higher total.
    assign outcome_exp = (status.player_total > 5'd21) ? DEALER_WIN :
                         (status.dealer_total > 5'd21) ? PLAYER_WIN :
                         (status.player_total > status.dealer_total) ? PLAYER_WIN :
                         (status.dealer_total > status.player_total) ? DEALER_WIN : PUSH;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
            h_seen   <= 1'b0;
            v_seen   <= 1'b0;
            h_low    <= 0;
            v_low    <= 0;
            h_period <= 0;
            h_pos    <= 0;
            v_pos    <= 0;
            status_q <= RESET_STATUS;
            left_q   <= 1'b0;
            deal_q   <= 1'b0;
        end else begin
            hsync_q  <= hsync;
            vsync_q  <= vsync;
            h_seen   <= h_seen || h_fall;
            v_seen   <= v_seen || v_fall;
            h_low    <= hsync ? 0 : h_low + 1;
            v_low    <= vsync ? 0 : v_low + 1;
            h_period <= h_fall ? 1 : h_period + 1;
            h_pos    <= (h_here == H_TOTAL - 1) ? 0 : h_here + 1;
            status_q <= status;
            left_q   <= mouse_left;
            deal_q   <= deal_press;
            if (h_here == H_TOTAL - 1) begin
                v_pos <= (v_here == V_TOTAL - 1) ? 0 : v_here + 1;   // Next line.
            end else begin
                v_pos <= v_here;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    a_reset_values: assert property (@(posedge clk) $rose(rst_n) |->
        (status == RESET_STATUS) && hsync && vsync && (rgb == '0))
        else begin
            fail_count++;
            $error("FAILED reset_values: expected %h, actual %h",
                   {RESET_STATUS, 2'b11, 12'h000}, {status, hsync, vsync, rgb});
        end

    a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        (hsync && !hsync_q) |-> (h_low == H_SYNC))
        else begin
            fail_count++;
            $error("FAILED hsync_width: expected %0d, actual %0d", H_SYNC, h_low);
        end

    a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        (h_fall && h_seen) |-> (h_period == H_TOTAL))
        else begin
            fail_count++;
            $error("FAILED hsync_period: expected %0d, actual %0d", H_TOTAL, h_period);
        end

    a_vsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        (vsync && !vsync_q) |-> (v_low == V_SYNC * H_TOTAL))
        else begin
            fail_count++;
            $error("FAILED vsync_width: expected %0d, actual %0d", V_SYNC * H_TOTAL, v_low);
        end

    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (h_seen && v_seen && ((h_here >= H_ACTIVE) || (v_here >= V_ACTIVE))) |-> (rgb == '0))
        else begin
            fail_count++;
            $error("FAILED blank_black: expected 000, actual %h at %0d,%0d",
                   rgb, h_here, v_here);
        end

    // ~~~~~~~~~~~~~~~~~~~~
    // Outside a hand only a press on the deal button may move the game.
    a_cmd_filter: assert property (@(posedge clk) disable iff (!rst_n)
        (((status.state == IDLE) || (status.state == RESULT)) && !deal_q) |=>
        (status == status_q))
        else begin
            fail_count++;
            $error("FAILED cmd_filter: expected %h, actual %h", status_q, status);
        end

    a_deal: assert property (@(posedge clk) disable iff (!rst_n)
        ((status_q.state == DEAL) && (status.state != DEAL)) |->
        (status.dealer_count == 3'd2) &&
        (((status.state == PLAYER_TURN) && (status.player_count == 3'd2) &&
          (status.player_total >= 5'd4) && (status.player_total <= 5'd21)) ||
         ((status.state == RESULT) && (status.outcome == DEALER_WIN))))
        else begin
            fail_count++;
            $error("FAILED deal: expected 2 cards each and total 4 to 21, actual %0d, %0d, %0d",
                   status.player_count, status.dealer_count, status.player_total);
        end

    a_dealer_rule: assert property (@(posedge clk) disable iff (!rst_n)
        ((status_q.state == DEALER_TURN) && (status.state == RESULT)) |->
        ((status.dealer_total >= 5'd17) || (status.dealer_count == 3'(MAX_CARDS))))
        else begin
            fail_count++;
            $error("FAILED dealer_rule: expected 17 or %0d cards, actual %0d with %0d cards",
                   MAX_CARDS, status.dealer_total, status.dealer_count);
        end

    a_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        (status.state == RESULT) |-> (status.outcome == outcome_exp))
        else begin
            fail_count++;
            $error("FAILED outcome: expected %s, actual %s",
                   outcome_exp.name(), status.outcome.name());
        end

endmodule

bind top_blackjack top_blackjack_assert #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT(H_FRONT),
    .H_SYNC(H_SYNC),
    .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT(V_FRONT),
    .V_SYNC(V_SYNC),
    .V_BACK(V_BACK)
) i_assert (.*);

/* verif/top_blackjack_tb.sv */
// Testbench for the blackjack table: clock, reset, random clicks on and
// around the buttons, and the closing summary.
module top_blackjack_tb;
    import blackjack_pkg::*;

    localparam int CYCLE_LIMIT = 2000;  // Longest wait for any one event.
    localparam int ROUNDS      = 200;

    logic         clk;
    logic         rst_n;
    logic [11:0]  mouse_x;
    logic [11:0]  mouse_y;
    logic         mouse_left;
    logic         hsync;
    logic         vsync;
    rgb_t         rgb;
    game_status_t status;
    logic [31:0]  rng_state;
    logic [2:0]   old_count;
    int           action;
    int           timeouts;
    int           failures;

    top_blackjack #(
        .H_ACTIVE(16), .H_FRONT(2), .H_SYNC(4), .H_BACK(2),
        .V_ACTIVE(8), .V_FRONT(1), .V_SYNC(2), .V_BACK(1)
    ) i_dut (.clk, .rst_n, .mouse_x, .mouse_y, .mouse_left, .hsync, .vsync, .rgb, .status);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Presses the left button at one spot, holds it, then lets go.
    task automatic click(input logic [11:0] x, input logic [11:0] y);
        @(negedge clk);
        mouse_x    = x;
        mouse_y    = y;
        mouse_left = 1'b1;
        repeat (3) @(negedge clk);
        mouse_left = 1'b0;
        repeat (2) @(negedge clk);    // Released long enough for the next press.
    endtask

    // Random spot inside a button, edges included.
    task automatic click_in(input logic [11:0] rx, input logic [11:0] ry,
                            input logic [11:0] w, input logic [11:0] h);
        click(rx + 12'(next_random() % w), ry + 12'(next_random() % h));
    endtask

    // Either above the button row or in the gap between deal and hit.
    task automatic click_outside();
        logic [11:0] gap;
        gap = BTN_HIT_X - BTN_DEAL_X - BTN_DEAL_W;
        if ((next_random() % 2) == 0) begin
            click(12'(next_random() % 640), 12'(next_random() % BTN_DEAL_Y));
        end else begin
            click(BTN_DEAL_X + BTN_DEAL_W + 12'(next_random() % gap),
                  BTN_HIT_Y + 12'(next_random() % BTN_HIT_H));
        end
    endtask

    task automatic wait_for_state(input game_state_t a, input game_state_t b);
        int cycles;
        cycles = 0;
        while ((status.state != a) && (status.state != b) && (cycles < CYCLE_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if ((status.state != a) && (status.state != b)) begin
            timeouts++;
            $display("Timeout: the game never reached %s or %s", a.name(), b.name());
        end
    endtask

    task automatic wait_for_card(input logic [2:0] count_before);
        int cycles;
        cycles = 0;
        while ((status.player_count == count_before) && (cycles < CYCLE_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (status.player_count == count_before) begin
            timeouts++;
            $display("Timeout: no card reached the player after a hit");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        mouse_x    = '0;
        mouse_y    = '0;
        mouse_left = 1'b0;
        rng_state  = 32'hcbbb;
        timeouts   = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int round = 0; (round < ROUNDS) && (timeouts == 0); round++) begin
            action = int'(next_random() % 4);
            if (status.state == PLAYER_TURN) begin
                if (action < 2) begin
                    old_count = status.player_count;
                    click_in(BTN_HIT_X, BTN_HIT_Y, BTN_HIT_W, BTN_HIT_H);
                    if (old_count < 3'(MAX_CARDS)) begin
                        wait_for_card(old_count);
                    end
                    if (status.player_total > 5'd21) begin
                        wait_for_state(RESULT, RESULT);    // Bust ends the hand.
                    end
                end else if (action == 2) begin
                    click_in(BTN_STAND_X, BTN_STAND_Y, BTN_STAND_W, BTN_STAND_H);
                    wait_for_state(RESULT, RESULT);
                end else begin
                    click_outside();
                end
            end else if (action == 0) begin
                click_in(BTN_HIT_X, BTN_HIT_Y, BTN_HIT_W, BTN_HIT_H);
            end else if (action == 1) begin
                click_in(BTN_STAND_X, BTN_STAND_Y, BTN_STAND_W, BTN_STAND_H);
            end else if (action == 2) begin
                click_outside();
            end else begin
                click_in(BTN_DEAL_X, BTN_DEAL_Y, BTN_DEAL_W, BTN_DEAL_H);
                wait_for_state(PLAYER_TURN, RESULT);
            end
        end
        failures = i_dut.i_assert.fail_count;
        $display("Summary: %0d assertion failures, %0d timeouts", failures, timeouts);
        if ((failures == 0) && (timeouts == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/blackjack_pkg.sv
logic/vga_timing.sv
logic/button_click.sv
logic/card_dealer.sv
logic/blackjack_fsm.sv
logic/draw_table.sv
logic/top_blackjack.sv
verif/top_blackjack_assert.sv
verif/top_blackjack_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := top_blackjack_tb
FILELIST  := verilog.f
RUN_ARGS  := +verilator+error+limit+1000
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := Simulation finished: PASS

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
